//--- dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam rv_pkg::word_t RESET_PC  = 64'h100;
    localparam rv_pkg::word_t DATA_BASE = 64'h400;
    localparam rv_pkg::inst_t NOP       = 32'h0000_0013;   // addi x0, x0, 0
    localparam int CLK_HALF      = 2;
    localparam int ROM_WORDS     = 128;
    localparam int MEM_WORDS     = 512;
    localparam int RUN_CYCLES    = 600;
    localparam int SETTLE_CYCLES = 20;
    localparam int NUM_RUNS      = 5;
    localparam int WATCHDOG_NS   = NUM_RUNS * (RUN_CYCLES + SETTLE_CYCLES + 10) * 2 * CLK_HALF;

    logic          clk;
    logic          reset;
    rv_pkg::word_t imem_addr;
    rv_pkg::inst_t imem_data;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    rv_pkg::word_t wb_adr;
    rv_pkg::word_t wb_dat_w;
    logic [7:0]    wb_sel;
    rv_pkg::word_t wb_dat_r;
    logic          wb_ack;

    rv_pkg::inst_t rom [ROM_WORDS];
    rv_pkg::word_t rom_off;
    int            rom_fill;
    rv_pkg::word_t mem [MEM_WORDS];
    logic [8:0]    mem_idx;
    logic          mem_pending;
    int            wait_left;
    logic [31:0]   lcg_state;
    rv_pkg::word_t log_adr [$];
    rv_pkg::word_t log_dat [$];
    logic [7:0]    log_sel [$];

    rv_core #(.RESET_PC(RESET_PC)) u_rv_core (
        .clk(clk), .reset(reset), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
    );

    always #CLK_HALF clk = ~clk;

    // Outside the program or off word alignment the ROM returns NOPs
    assign rom_off   = imem_addr - RESET_PC;
    assign imem_data = (rom_off[63:9] == '0 && rom_off[1:0] == 2'b00) ? rom[rom_off[8:2]] : NOP;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t addr);
        return {~addr[31:0], addr[31:0]};
    endfunction

    function automatic rv_pkg::word_t lane_mask(input logic [7:0] sel);
        rv_pkg::word_t m;
        for (int b = 0; b < 8; b++)
            m[8*b +: 8] = {8{sel[b]}};
        return m;
    endfunction

    function automatic rv_pkg::word_t addr_of(input int idx);
        return RESET_PC + rv_pkg::word_t'(4 * idx);
    endfunction

    function automatic rv_pkg::inst_t i_type(input logic [31:0] imm, input logic [31:0] rs1,
                                             input logic [31:0] f3, input logic [31:0] rd,
                                             input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv_pkg::inst_t r_type(input logic [31:0] f7, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [31:0] f3,
                                             input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::op_reg};
    endfunction

    function automatic rv_pkg::inst_t s_type(input logic [31:0] imm, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::inst_t b_type(input logic [31:0] imm, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::inst_t u_type(input logic [31:0] imm, input logic [31:0] rd,
                                             input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic rv_pkg::inst_t j_type(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::op_jal};
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic emit(input rv_pkg::inst_t w);
        rom[rom_fill] = w;
        rom_fill++;
    endtask

    // Complete the access that is acked in this cycle
    task automatic serve_access();
        mem_idx = wb_adr[11:3];
        if (wb_we) begin
            for (int b = 0; b < 8; b++)
                if (wb_sel[b])
                    mem[mem_idx][8*b +: 8] = wb_dat_w[8*b +: 8];
            log_adr.push_back(wb_adr);
            log_dat.push_back(wb_dat_w);
            log_sel.push_back(wb_sel);
        end
        wb_dat_r = mem[mem_idx];
    endtask

    // Wishbone slave with 0 to 3 wait states per access
    always @(negedge clk) begin
        if (!reset) begin
            wb_ack      = 1'b0;
            mem_pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack      = 1'b0;   // Transfer ended at the last rising edge
            mem_pending = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!mem_pending) begin
                mem_pending = 1'b1;
                wait_left   = next_random() % 4;
            end
            if (wait_left == 0) begin
                serve_access();
                wb_ack = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic hold_reset();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = NOP;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(rv_pkg::word_t'(i) << 3);
        log_adr.delete();
        log_dat.delete();
        log_sel.delete();
        rom_fill = 0;
        @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic release_reset();
        repeat (3) begin
            @(negedge clk);
            assert (imem_addr == RESET_PC) else
                report_failure($sformatf("[ERROR] %0t: pc %h during reset", $time, imem_addr));
            assert (!wb_cyc && !wb_stb) else
                report_failure($sformatf("[ERROR] %0t: bus cycle during reset", $time));
        end
        reset = 1'b1;
        #1;
        assert (imem_addr == RESET_PC && !wb_cyc && !wb_stb) else
            report_failure($sformatf("[ERROR] %0t: pc %h or bus wrong after reset",
                                     $time, imem_addr));
    endtask

    task automatic run_until_stores(input int n);
        int cycles;
        cycles = 0;
        while (log_adr.size() < n && cycles < RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        assert (log_adr.size() >= n) else
            report_failure($sformatf("Core logged only %0d of %0d stores within %0d cycles",
                                     log_adr.size(), n, RUN_CYCLES));
        repeat (SETTLE_CYCLES) @(negedge clk);   // Catch stray stores
        assert (log_adr.size() == n) else
            report_failure($sformatf("[ERROR] %0t: %0d stores logged, expected %0d",
                                     $time, log_adr.size(), n));
    endtask

    task automatic expect_store(input int k, input rv_pkg::word_t adr,
                                input rv_pkg::word_t dat, input logic [7:0] sel);
        rv_pkg::word_t mask;
        mask = lane_mask(sel);   // Lanes outside sel are don't care
        assert (log_adr[k] == adr && log_sel[k] == sel && (log_dat[k] & mask) == (dat & mask))
        else
            report_failure($sformatf("[ERROR] %0t: store %0d %h %h %h, expected %h %h %h",
                                     $time, k, log_adr[k], log_dat[k], log_sel[k],
                                     adr, dat, sel));
    endtask

    task automatic check_reset();
        hold_reset();
        emit(j_type(0, 0));
        release_reset();
        @(negedge clk);
        assert (imem_addr == RESET_PC + 64'd4 && !wb_cyc && !wb_stb) else
            report_failure($sformatf("[ERROR] %0t: first cycle pc %h cyc %b",
                                     $time, imem_addr, wb_cyc));
    endtask

    task automatic arith_chain();
        int            src_reg [8] = '{3, 4, 5, 6, 7, 8, 9, 11};
        rv_pkg::word_t expected [8];
        rv_pkg::word_t r1, r2, r3, r4, r5, r6, r7, r8, r9, r11;
        hold_reset();
        emit(i_type(32'h400, 0, 0, 10, rv_pkg::op_imm));
        emit(i_type(-5, 0, 0, 1, rv_pkg::op_imm));
        emit(u_type(32'h80000, 2, rv_pkg::op_lui));
        emit(r_type(32, 2, 1, 0, 3));                    // sub x3, x1, x2
        emit(i_type(33, 3, 1, 4, rv_pkg::op_imm));       // slli x4, x3, 33
        emit(i_type(32'h404, 2, 5, 5, rv_pkg::op_imm));  // srai x5, x2, 4
        emit(i_type(60, 5, 5, 6, rv_pkg::op_imm));       // srli x6, x5, 60
        emit(r_type(0, 6, 5, 2, 7));                     // slt
        emit(r_type(0, 6, 5, 3, 8));                     // sltu
        emit(u_type(32'h12345, 9, rv_pkg::op_auipc));    // at index 9
        emit(r_type(0, 7, 6, 1, 11));                    // sll x11, x6, x7
        for (int k = 0; k < 8; k++)
            emit(s_type(8 * k, src_reg[k], 10, 3));
        emit(j_type(0, 0));
        release_reset();
        r1  = -64'd5;
        r2  = {{32{1'b1}}, 32'h8000_0000};   // U immediate sign-extended to 64 bits
        r3  = r1 - r2;
        r4  = r3 << 33;
        r5  = {{4{r2[63]}}, r2[63:4]};       // Sign bit fills the vacated top bits
        r6  = r5 >> 60;
        r7  = (r5[63] != r6[63]) ? {63'd0, r5[63]} : {63'd0, r5 < r6};
        r8  = (r5 < r6) ? 64'd1 : 64'd0;
        r9  = addr_of(9) + 64'h1234_5000;
        r11 = r6 << r7[5:0];
        expected = '{r3, r4, r5, r6, r7, r8, r9, r11};
        run_until_stores(8);
        for (int k = 0; k < 8; k++)
            expect_store(k, DATA_BASE + rv_pkg::word_t'(8 * k), expected[k], 8'hFF);
    endtask

    task automatic branch_paths();
        int f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int lhs [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
        int rhs [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
        bit taken [12] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};
        hold_reset();
        emit(i_type(32'h400, 0, 0, 10, rv_pkg::op_imm));
        emit(i_type(-1, 0, 0, 1, rv_pkg::op_imm));   // x1 = -1, x2 = x3 = 1
        emit(i_type(1, 0, 0, 2, rv_pkg::op_imm));
        emit(i_type(1, 0, 0, 3, rv_pkg::op_imm));
        emit(i_type(32'h11, 0, 0, 21, rv_pkg::op_imm));  // Fall-through marker
        emit(i_type(32'h22, 0, 0, 22, rv_pkg::op_imm));  // Taken marker
        for (int k = 0; k < 12; k++) begin
            emit(b_type(12, rhs[k], lhs[k], f3s[k]));
            emit(s_type(8 * k, 21, 10, 3));
            emit(j_type(8, 0));                           // Skip the taken-path store
            emit(s_type(8 * k, 22, 10, 3));
        end
        emit(j_type(0, 0));
        release_reset();
        run_until_stores(12);
        for (int k = 0; k < 12; k++)
            expect_store(k, DATA_BASE + rv_pkg::word_t'(8 * k),
                         taken[k] ? 64'h22 : 64'h11, 8'hFF);
    endtask

    task automatic jump_links();
        hold_reset();
        emit(i_type(32'h400, 0, 0, 10, rv_pkg::op_imm));
        emit(j_type(12, 1));                              // jal x1 to index 4
        emit(s_type(0, 0, 10, 3));
        emit(s_type(0, 0, 10, 3));
        emit(s_type(0, 1, 10, 3));
        emit(i_type(32'(addr_of(9) + 1), 0, 0, 5, rv_pkg::op_imm));  // JALR must clear bit 0
        emit(i_type(0, 5, 0, 2, rv_pkg::op_jalr));
        emit(s_type(8, 0, 10, 3));
        emit(s_type(8, 0, 10, 3));
        emit(s_type(8, 2, 10, 3));
        emit(j_type(0, 0));
        release_reset();
        run_until_stores(2);
        expect_store(0, DATA_BASE, addr_of(1) + 64'd4, 8'hFF);
        expect_store(1, DATA_BASE + 64'd8, addr_of(6) + 64'd4, 8'hFF);
    endtask

    task automatic memory_waits();
        rv_pkg::word_t r1, r2, hi_fill;
        hold_reset();
        emit(i_type(32'h400, 0, 0, 10, rv_pkg::op_imm));
        emit(u_type(32'hDEADC, 1, rv_pkg::op_lui));
        emit(i_type(-32'h111, 1, 0, 1, rv_pkg::op_imm));
        emit(i_type(20, 1, 1, 2, rv_pkg::op_imm));        // slli x2, x1, 20
        emit(i_type(32'h5A5, 2, 4, 2, rv_pkg::op_imm));   // xori
        emit(s_type(0, 2, 10, 3));
        emit(i_type(0, 10, 3, 3, rv_pkg::op_load));       // ld x3
        emit(s_type(8, 3, 10, 3));
        emit(s_type(20, 1, 10, 2));                       // sw to upper half
        emit(s_type(24, 1, 10, 2));                       // sw to lower half
        emit(i_type(20, 10, 2, 4, rv_pkg::op_load));
        emit(s_type(32, 4, 10, 3));
        emit(i_type(28, 10, 2, 5, rv_pkg::op_load));      // Untouched upper half
        emit(s_type(40, 5, 10, 3));
        emit(j_type(0, 0));
        release_reset();
        r1      = {{32{1'b1}}, 20'hDEADC, 12'h000} - 64'h111;
        r2      = (r1 << 20) ^ 64'h5A5;
        hi_fill = fill_word(DATA_BASE + 64'h18);
        run_until_stores(6);
        expect_store(0, DATA_BASE, r2, 8'hFF);
        expect_store(1, DATA_BASE + 64'h08, r2, 8'hFF);
        expect_store(2, DATA_BASE + 64'h10, {r1[31:0], 32'h0}, 8'hF0);
        expect_store(3, DATA_BASE + 64'h18, {32'h0, r1[31:0]}, 8'h0F);
        expect_store(4, DATA_BASE + 64'h20, {{32{r1[31]}}, r1[31:0]}, 8'hFF);
        expect_store(5, DATA_BASE + 64'h28, {{32{hi_fill[63]}}, hi_fill[63:32]}, 8'hFF);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b0;
        wb_ack    = 1'b0;
        wb_dat_r  = '0;
        lcg_state = 32'd50;
        rom_fill  = 0;
        check_reset();
        arith_chain();
        branch_paths();
        jump_links();
        memory_waits();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  wire                clk,
    input  wire                reset,
    output rv_pkg::word_t      imem_addr_o,
    input  wire rv_pkg::inst_t imem_data_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output rv_pkg::word_t      wb_adr_o,
    output rv_pkg::word_t      wb_dat_o,
    output logic [7:0]         wb_sel_o,
    input  wire rv_pkg::word_t wb_dat_i,
    input  wire                wb_ack_i
);

    rv_pkg::fetch_t     if_data;
    rv_pkg::fetch_t     fd_data;
    logic               fd_valid;
    rv_pkg::decode_t    id_data;
    logic               id_valid;
    rv_pkg::decode_t    de_data;
    logic               de_valid;
    rv_pkg::ex_result_t ex_result;
    rv_pkg::redirect_t  redirect;
    rv_pkg::wb_t        wb;
    logic               stall;
    rv_pkg::reg_idx_t   rs1_idx;
    rv_pkg::reg_idx_t   rs2_idx;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;

    rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .stall_i(stall), .redirect_i(redirect),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o), .fetch_o(if_data)
    );

    // Fetch always offers a valid slot, flushes insert the bubbles
    rv_stage_reg #(.PAYLOAD_T(rv_pkg::fetch_t)) u_fd (
        .clk(clk), .reset(reset), .stall_i(stall), .flush_i(redirect.taken),
        .valid_i(1'b1), .data_i(if_data), .valid_o(fd_valid), .data_o(fd_data)
    );

    rv_decode u_decode (
        .valid_i(fd_valid), .fetch_i(fd_data),
        .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .valid_o(id_valid), .decode_o(id_data)
    );

    rv_regfile u_regfile (
        .clk(clk), .reset(reset), .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wb_i(wb)
    );

    rv_stage_reg #(.PAYLOAD_T(rv_pkg::decode_t)) u_de (
        .clk(clk), .reset(reset), .stall_i(stall), .flush_i(redirect.taken),
        .valid_i(id_valid), .data_i(id_data), .valid_o(de_valid), .data_o(de_data)
    );

    rv_execute u_execute (
        .valid_i(de_valid), .decode_i(de_data),
        .result_o(ex_result), .redirect_o(redirect)
    );

    rv_lsu u_lsu (
        .result_i(ex_result),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .wb_o(wb), .stall_o(stall)
    );

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire                 valid_i,
    input  wire rv_pkg::fetch_t fetch_i,
    output rv_pkg::reg_idx_t    rs1_idx_o,
    output rv_pkg::reg_idx_t    rs2_idx_o,
    input  wire rv_pkg::word_t  rs1_data_i,
    input  wire rv_pkg::word_t  rs2_data_i,
    output logic                valid_o,
    output rv_pkg::decode_t     decode_o
);

    rv_pkg::inst_t    inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    imm_s;
    rv_pkg::word_t    imm_b;
    rv_pkg::word_t    imm_u;
    rv_pkg::word_t    imm_j;

    // Alt selects sub and sra, taken from funct7 bit 5
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rs1_idx_o = inst[19:15];
    assign rs2_idx_o = inst[24:20];
    assign valid_o   = valid_i;

    always_comb begin
        decode_o         = '0;   // Unknown opcodes fall through as no-ops
        decode_o.pc      = fetch_i.pc;
        decode_o.rs1_val = rs1_data_i;
        decode_o.rs2_val = rs2_data_i;
        decode_o.rd      = rd;
        decode_o.funct3  = funct3;
        decode_o.alu_op  = rv_pkg::alu_add;
        decode_o.mem_op  = rv_pkg::mem_none;
        case (opcode)
            rv_pkg::op_lui: begin
                decode_o.imm       = imm_u;
                decode_o.use_imm   = 1'b1;
                decode_o.alu_op    = rv_pkg::alu_pass_b;
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                decode_o.imm       = imm_u;
                decode_o.use_imm   = 1'b1;
                decode_o.use_pc    = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_jal: begin
                decode_o.imm       = imm_j;
                decode_o.is_jal    = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_jalr: begin
                decode_o.imm       = imm_i;
                decode_o.is_jalr   = 1'b1;
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_branch: begin
                decode_o.imm       = imm_b;
                decode_o.is_branch = 1'b1;
            end
            rv_pkg::op_load: begin
                decode_o.imm       = imm_i;
                decode_o.use_imm   = 1'b1;
                decode_o.mem_op    = rv_pkg::mem_load;
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                decode_o.imm     = imm_s;
                decode_o.use_imm = 1'b1;
                decode_o.mem_op  = rv_pkg::mem_store;
            end
            rv_pkg::op_imm: begin
                decode_o.imm       = imm_i;   // Shamt sits in imm[5:0]
                decode_o.use_imm   = 1'b1;
                decode_o.alu_op    = alu_sel(funct3, (funct3 == 3'b101) && inst[30]);
                decode_o.reg_write = 1'b1;
            end
            rv_pkg::op_reg: begin
                decode_o.alu_op    = alu_sel(funct3, inst[30]);
                decode_o.reg_write = 1'b1;
            end
            default: ;
        endcase
        if (rd == '0)
            decode_o.reg_write = 1'b0;   // x0 stays zero
    end

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire                  valid_i,
    input  wire rv_pkg::decode_t decode_i,
    output rv_pkg::ex_result_t   result_o,
    output rv_pkg::redirect_t    redirect_o
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [5:0]    shamt;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t link;
    rv_pkg::word_t jalr_sum;
    logic          cond;
    logic          is_jump;

    assign op_a  = decode_i.use_pc  ? decode_i.pc  : decode_i.rs1_val;
    assign op_b  = decode_i.use_imm ? decode_i.imm : decode_i.rs2_val;
    assign shamt = op_b[5:0];

    always_comb begin
        case (decode_i.alu_op)
            rv_pkg::alu_add:    alu_res = op_a + op_b;
            rv_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_pkg::alu_sll:    alu_res = op_a << shamt;
            rv_pkg::alu_slt:    alu_res = {{(rv_pkg::xlen-1){1'b0}},
                                           $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_res = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
            rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_res = op_a >> shamt;
            rv_pkg::alu_sra:    alu_res = rv_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pkg::alu_or:     alu_res = op_a | op_b;
            rv_pkg::alu_and:    alu_res = op_a & op_b;
            rv_pkg::alu_pass_b: alu_res = op_b;   // LUI
            default:            alu_res = op_a + op_b;
        endcase
    end

    // Branch compare always works on the two register values
    always_comb begin
        case (decode_i.funct3)
            3'b000:  cond = decode_i.rs1_val == decode_i.rs2_val;
            3'b001:  cond = decode_i.rs1_val != decode_i.rs2_val;
            3'b100:  cond = $signed(decode_i.rs1_val) <  $signed(decode_i.rs2_val);
            3'b101:  cond = $signed(decode_i.rs1_val) >= $signed(decode_i.rs2_val);
            3'b110:  cond = decode_i.rs1_val <  decode_i.rs2_val;
            3'b111:  cond = decode_i.rs1_val >= decode_i.rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign is_jump  = decode_i.is_jal || decode_i.is_jalr;
    assign link     = decode_i.pc + rv_pkg::word_t'(4);
    assign jalr_sum = decode_i.rs1_val + decode_i.imm;

    assign redirect_o.taken  = valid_i && (is_jump || (decode_i.is_branch && cond));
    assign redirect_o.target = decode_i.is_jalr ? {jalr_sum[rv_pkg::xlen-1:1], 1'b0}
                                                : decode_i.pc + decode_i.imm;

    assign result_o.rd         = decode_i.rd;
    assign result_o.reg_write  = valid_i && decode_i.reg_write;
    assign result_o.value      = is_jump ? link : alu_res;
    assign result_o.mem_op     = valid_i ? decode_i.mem_op : rv_pkg::mem_none;
    assign result_o.mem_addr   = alu_res;   // rs1 + imm for loads and stores
    assign result_o.store_data = decode_i.rs2_val;
    assign result_o.is_double  = decode_i.funct3 == 3'b011;

endmodule

`default_nettype wire

//--- rtl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    stall_i,
    input  wire rv_pkg::redirect_t redirect_i,
    input  wire rv_pkg::inst_t     imem_data_i,
    output rv_pkg::word_t          imem_addr_o,
    output rv_pkg::fetch_t         fetch_o
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;

    // Redirect wins, a branch in execute never coincides with a memory stall
    always_comb begin
        if (redirect_i.taken)
            pc_next = redirect_i.target;
        else if (stall_i)
            pc_next = pc;
        else
            pc_next = pc + rv_pkg::word_t'(4);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

    assign imem_addr_o  = pc;
    assign fetch_o.pc   = pc;
    assign fetch_o.inst = imem_data_i;   // Instruction returns in the same cycle

endmodule

`default_nettype wire

//--- rtl/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
    input  wire rv_pkg::ex_result_t result_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output rv_pkg::word_t           wb_adr_o,
    output rv_pkg::word_t           wb_dat_o,
    output logic [7:0]              wb_sel_o,
    input  wire rv_pkg::word_t      wb_dat_i,
    input  wire                     wb_ack_i,
    output rv_pkg::wb_t             wb_o,
    output logic                    stall_o
);

    logic          mem_access;
    logic          upper;        // Word sits in bytes 7..4
    logic [31:0]   load_half;
    rv_pkg::word_t load_data;

    assign mem_access = result_i.mem_op != rv_pkg::mem_none;
    assign upper      = result_i.mem_addr[2];

    // Request held stable by the stalled pipeline until ack
    assign wb_cyc_o = mem_access;
    assign wb_stb_o = mem_access;
    assign wb_we_o  = result_i.mem_op == rv_pkg::mem_store;
    assign wb_adr_o = {result_i.mem_addr[rv_pkg::xlen-1:3], 3'b000};

    always_comb begin
        if (result_i.is_double) begin
            wb_sel_o = 8'hFF;
            wb_dat_o = result_i.store_data;
        end else if (upper) begin
            wb_sel_o = 8'hF0;
            wb_dat_o = {result_i.store_data[31:0], 32'b0};
        end else begin
            wb_sel_o = 8'h0F;
            wb_dat_o = {32'b0, result_i.store_data[31:0]};
        end
    end

    assign load_half = upper ? wb_dat_i[63:32] : wb_dat_i[31:0];
    assign load_data = result_i.is_double ? wb_dat_i : {{32{load_half[31]}}, load_half};

    // Loads retire in the ack cycle, ALU ops straight away
    assign wb_o.valid = result_i.reg_write &&
                        (!mem_access || (result_i.mem_op == rv_pkg::mem_load && wb_ack_i));
    assign wb_o.rd    = result_i.rd;
    assign wb_o.value = mem_access ? load_data : result_i.value;

    assign stall_o = mem_access && !wb_ack_i;

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes of the supported RV64I subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none, mem_load, mem_store
    } mem_op_t;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rd;
        alu_op_t  alu_op;
        logic     use_imm;   // Operand b is the immediate
        logic     use_pc;    // Operand a is the pc
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     reg_write;
        logic [2:0] funct3;
        mem_op_t  mem_op;
    } decode_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        word_t    value;      // ALU result or link address
        mem_op_t  mem_op;
        word_t    mem_addr;
        word_t    store_data;
        logic     is_double;  // LD/SD, otherwise LW/SW
    } ex_result_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                   clk,
    input  wire                   reset,
    input  wire rv_pkg::reg_idx_t rs1_idx_i,
    input  wire rv_pkg::reg_idx_t rs2_idx_i,
    output rv_pkg::word_t         rs1_data_o,
    output rv_pkg::word_t         rs2_data_o,
    input  wire rv_pkg::wb_t      wb_i
);

    rv_pkg::word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    // Write-through so decode sees the result retiring in execute
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wb_i.valid && wb_i.rd == rs1_idx_i) ? wb_i.value : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wb_i.valid && wb_i.rd == rs2_idx_i) ? wb_i.value : regs[rs2_idx_i];

endmodule

`default_nettype wire

//--- rtl/rv_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_stage_reg #(
    parameter type PAYLOAD_T = rv_pkg::fetch_t
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           stall_i,
    input  wire           flush_i,
    input  wire           valid_i,
    input  wire PAYLOAD_T data_i,
    output logic          valid_o,
    output PAYLOAD_T      data_o
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;   // Wrong-path slot becomes a bubble
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i)
            data_o <= data_i;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- src.f
rtl/rv_pkg.sv
rtl/rv_stage_reg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
dv/tb_rv_core.sv
